// ==== rtl/periph_defs.svh ====
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// address bits 31:5 that select the peripheral window
// top 32 byte addresses, ffff_ffe0 and up
`define PERIPH_WINDOW_TAG 27'h7ff_ffff

// gpio sits below the window, matched on the full address
`define GPIO_ADDR 32'hffff_ff00

// i2c register offsets inside the window
`define I2C_STATUS_OFS 5'h07
`define I2C_ADDR_OFS 5'h08
`define I2C_DATA_OFS 5'h09

// status register bit positions
// busy and txfull both mirror the master busy level
`define STAT_BUSY 1
`define STAT_TXFULL 2
// go is write-only, reads back 0
`define STAT_GO 4

// clk cycles per i2c tick, keep at 2 or more
`define I2C_DIV 8

// address byte plus two data bytes
`define I2C_FRAME_BYTES 3

`endif

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

	// byte address on the cpu data bus
	typedef logic [31:0] addr_t;

	// one data word on the bus
	// also used for readback from the register block
	typedef logic [31:0] word_t;

	// gpio output pins
	// only the low half of a written word lands here
	typedef logic [15:0] gpio_t;

endpackage

// ==== rtl/i2c_pkg.sv ====
package i2c_pkg;

	// one byte on the wire
	typedef logic [7:0] i2c_byte_t;

	// payload word, sent high byte first
	typedef logic [15:0] i2c_data_t;

	// address byte then payload, msb goes out first
	typedef logic [23:0] i2c_frame_t;

	// write-only master, one tick per state
	typedef enum logic [2:0] {
		idle,
		start,
		bit_low,
		bit_high,
		ack_low,
		ack_high,
		stop_low,
		stop_high
	} i2c_state_t;

endpackage

// ==== rtl/addr_decode.sv ====
`timescale 1ns/1ns

`include "periph_defs.svh"

module addr_decode (
	input  bus_pkg::addr_t adr,
	input  bus_pkg::word_t mmemdata,
	input  bus_pkg::word_t mmemdatah,
	input  bus_pkg::word_t regdata,
	output logic           menable,
	output logic           denable,
	output bus_pkg::word_t memdata
);
	import bus_pkg::*;

	// main memory bank picked by the top address bit
	word_t bank_data;

	// window hit when the upper 27 bits are all ones
	// low 5 bits are the register offset, ignored here
	assign denable = (adr[31:5] == `PERIPH_WINDOW_TAG);

	// main memory only outside the window
	assign menable = ~denable;

	// high bank for bit 31 set, low bank otherwise
	assign bank_data = adr[31] ? mmemdatah : mmemdata;

	// window reads come from the register block
	// everything else from the selected bank
	// all paths combinational, same cycle as adr
	assign memdata = denable ? regdata : bank_data;

endmodule

// ==== rtl/io_regs.sv ====
`timescale 1ns/1ns

`include "periph_defs.svh"

module io_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                denable,
	input  logic                memwrite,
	input  bus_pkg::addr_t      adr,
	input  bus_pkg::word_t      writedata,
	output bus_pkg::word_t      regdata,
	output bus_pkg::gpio_t      gpio,
	output logic                go,
	output i2c_pkg::i2c_frame_t frame,
	input  logic                busy,
	input  logic                done
);
	import bus_pkg::*;
	import i2c_pkg::*;

	// slave address byte and payload word
	i2c_byte_t addr_q;
	i2c_data_t data_q;
	// write strobes, one per register
	logic      status_wr;
	logic      addr_wr;
	logic      data_wr;
	logic      gpio_wr;
	// status as seen by the cpu
	word_t     status_word;

	// window writes need the decoder hit and the offset
	assign status_wr = denable && memwrite && (adr[4:0] == `I2C_STATUS_OFS);
	assign addr_wr   = denable && memwrite && (adr[4:0] == `I2C_ADDR_OFS);
	assign data_wr   = denable && memwrite && (adr[4:0] == `I2C_DATA_OFS);
	// gpio is outside the window, full address match
	assign gpio_wr   = memwrite && (adr == `GPIO_ADDR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gpio   <= '0;
			go     <= 1'b0;
			addr_q <= '0;
			data_q <= '0;
		end else begin
			if (gpio_wr) begin
				gpio <= writedata[15:0];
			end
			// go pulses the cycle after the status write
			go <= status_wr && writedata[`STAT_GO];
			// frame sent, registers read back empty
			if (done) begin
				addr_q <= '0;
				data_q <= '0;
			end
			// a fresh cpu write beats the clear
			if (addr_wr) begin
				addr_q <= writedata[7:0];
			end
			if (data_wr) begin
				data_q <= writedata[15:0];
			end
		end
	end

	// go bit never stored, only busy shows up
	always_comb begin
		status_word = '0;
		status_word[`STAT_BUSY]   = busy;
		status_word[`STAT_TXFULL] = busy;
	end

	// readback mux, decoder only uses it inside the window
	always_comb begin
		case (adr[4:0])
			`I2C_STATUS_OFS: regdata = status_word;
			`I2C_ADDR_OFS:   regdata = word_t'(addr_q);
			`I2C_DATA_OFS:   regdata = word_t'(data_q);
			default:         regdata = '0;
		endcase
	end

	// address byte leads the frame
	assign frame = {addr_q, data_q};

endmodule

// ==== rtl/i2c_master.sv ====
`timescale 1ns/1ns

`include "periph_defs.svh"

module i2c_master (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                go,
	input  i2c_pkg::i2c_frame_t frame,
	output logic                scl,
	output logic                sda_out,
	output logic                sda_oe,
	output logic                busy,
	output logic                done
);
	import i2c_pkg::*;

	localparam int DIV_W      = $clog2(`I2C_DIV);
	localparam int FRAME_BITS = `I2C_FRAME_BYTES * 8;
	localparam int CNT_W      = $clog2(FRAME_BITS + 1);

	i2c_state_t       state;
	i2c_state_t       state_nxt;
	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	// bits already sent
	// low three bits mark byte ends
	logic [CNT_W-1:0] bit_cnt;
	i2c_frame_t       shift_q;
	logic             sda_nxt;
	logic             oe_nxt;

	// one tick per state
	assign tick = (div_cnt == DIV_W'(`I2C_DIV - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			start:    state_nxt = bit_low;
			bit_low:  state_nxt = bit_high;
			// ack slot after every eighth bit
			bit_high: state_nxt = (bit_cnt[2:0] == 3'd7) ? ack_low : bit_low;
			ack_low:  state_nxt = ack_high;
			ack_high: state_nxt = (bit_cnt == CNT_W'(FRAME_BITS)) ? stop_low : bit_low;
			stop_low: state_nxt = stop_high;
			default:  state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= idle;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (state == idle) begin
			// divider restarts so start gets a full tick
			div_cnt <= '0;
			if (go) begin
				state   <= start;
				bit_cnt <= '0;
			end
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				state <= state_nxt;
			end
			if (tick && (state == bit_high)) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// frame latched on an accepted go
	// shifted out msb first
	always_ff @(posedge clk) begin
		if ((state == idle) && go) begin
			shift_q <= frame;
		end else if (tick && (state == bit_high)) begin
			shift_q <= shift_q << 1;
		end
	end

	// sda level and enable per state
	// ack slots release the line
	// no ack check
	// stop_high lets sda rise for the stop edge
	always_comb begin
		sda_nxt = 1'b1;
		oe_nxt  = 1'b1;
		case (state)
			start, stop_low:   sda_nxt = 1'b0;
			bit_low, bit_high: sda_nxt = shift_q[FRAME_BITS-1];
			ack_low, ack_high: oe_nxt  = 1'b0;
			default:           sda_nxt = 1'b1;
		endcase
	end

	// sda lags scl by one clk
	// data moves only after scl has fallen
	// start and stop edges land while scl is high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sda_out <= 1'b1;
			sda_oe  <= 1'b1;
		end else begin
			sda_out <= sda_nxt;
			sda_oe  <= oe_nxt;
		end
	end

	// scl low only in the low phases
	assign scl = !((state == bit_low) || (state == ack_low) || (state == stop_low));

	assign busy = (state != idle);

	// last cycle of the stop tick
	// busy drops on the next clk
	assign done = tick && (state == stop_high);

endmodule

// ==== rtl/periph_top.sv ====
`timescale 1ns/1ns

module periph_top (
	input  logic           clk,
	input  logic           rst_n,
	input  bus_pkg::addr_t adr,
	input  bus_pkg::word_t writedata,
	input  bus_pkg::word_t mmemdata,
	input  bus_pkg::word_t mmemdatah,
	input  logic           memwrite,
	output bus_pkg::word_t memdata,
	output logic           menable,
	output logic           denable,
	output bus_pkg::gpio_t gpio,
	output logic           scl,
	output logic           sda_out,
	output logic           sda_oe
);
	import bus_pkg::*;
	import i2c_pkg::*;

	// register readback into the decoder mux
	word_t      regdata;
	// register block to master
	i2c_frame_t frame;
	logic       go;
	// master back to register block
	logic       busy;
	logic       done;

	addr_decode u_addr_decode (
		.adr       (adr),
		.mmemdata  (mmemdata),
		.mmemdatah (mmemdatah),
		.regdata   (regdata),
		.menable   (menable),
		.denable   (denable),
		.memdata   (memdata)
	);

	io_regs u_io_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.denable   (denable),
		.memwrite  (memwrite),
		.adr       (adr),
		.writedata (writedata),
		.regdata   (regdata),
		.gpio      (gpio),
		.go        (go),
		.frame     (frame),
		.busy      (busy),
		.done      (done)
	);

	i2c_master u_i2c_master (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.frame   (frame),
		.scl     (scl),
		.sda_out (sda_out),
		.sda_oe  (sda_oe),
		.busy    (busy),
		.done    (done)
	);

endmodule

// ==== dv/tb_periph.sv ====
`timescale 1ns/1ns

`include "periph_defs.svh"

module tb_periph;
	import bus_pkg::*;

	localparam int MAX_OPS = 64;
	localparam int CLK_HALF = 4;
	// status while a frame is on the wire
	localparam word_t BUSY_WORD = (32'h1 << `STAT_BUSY) | (32'h1 << `STAT_TXFULL);

	logic        clk;
	logic        rst_n;
	addr_t       adr;
	word_t       writedata;
	word_t       mmemdata;
	word_t       mmemdatah;
	logic        memwrite;
	word_t       memdata;
	logic        menable;
	logic        denable;
	gpio_t       gpio;
	logic        scl;
	logic        sda_out;
	logic        sda_oe;

	// four words per operation
	logic [31:0] stim [0:MAX_OPS*4-1];
	int          num_ops;
	logic        stim_loaded;
	integer      seed;
	int          errors;
	int          proto_errors;
	// expected register contents
	logic [7:0]  model_addr;
	logic [15:0] model_data;
	gpio_t       model_gpio;
	// pin monitor state
	logic        prev_scl;
	logic        prev_sda;
	logic        in_frame;
	int          scl_rises;
	int          start_cnt;
	int          stop_cnt;
	int          mon_nbits;
	logic [23:0] mon_bits;

	periph_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.adr       (adr),
		.writedata (writedata),
		.mmemdata  (mmemdata),
		.mmemdatah (mmemdatah),
		.memwrite  (memwrite),
		.memdata   (memdata),
		.menable   (menable),
		.denable   (denable),
		.gpio      (gpio),
		.scl       (scl),
		.sda_out   (sda_out),
		.sda_oe    (sda_oe)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	// window is the top 32 byte addresses
	function automatic logic in_window(input addr_t a);
		return a >= {`PERIPH_WINDOW_TAG, 5'h0};
	endfunction

	// one write cycle with memwrite dropped on the next falling edge
	task automatic bus_write(input addr_t a, input word_t d);
		@(negedge clk);
		adr       = a;
		writedata = d;
		memwrite  = 1'b1;
		@(negedge clk);
		memwrite  = 1'b0;
	endtask

	// fresh bank data on every read
	// memdata sampled in the middle of the low phase
	task automatic bus_read(input addr_t a, output word_t d);
		@(negedge clk);
		adr       = a;
		memwrite  = 1'b0;
		mmemdata  = $random(seed);
		mmemdatah = $random(seed);
		#2;
		d = memdata;
	endtask

	// register readback expected while idle
	// status reads 0 with no frame running
	function automatic word_t reg_model(input logic [4:0] ofs);
		case (ofs)
			`I2C_ADDR_OFS: return {24'h0, model_addr};
			`I2C_DATA_OFS: return {16'h0, model_data};
			default:       return 32'h0;
		endcase
	endfunction

	// decode and read data for one address
	task automatic access_check(input addr_t a, input word_t exp_win);
		word_t d;
		logic  in_win;
		in_win = in_window(a);
		bus_read(a, d);
		check_bit("denable", denable, in_win);
		check_bit("menable", menable, !in_win);
		if (in_win) begin
			check_value("memdata", d, exp_win);
		end else if (a[31]) begin
			check_value("memdata", d, mmemdatah);
		end else begin
			check_value("memdata", d, mmemdata);
		end
	endtask

	// write plus model update
	// gpio follows only its own address
	task automatic apply_write(input addr_t a, input word_t d);
		bus_write(a, d);
		if (a == `GPIO_ADDR) begin
			model_gpio = d[15:0];
		end
		if (in_window(a) && (a[4:0] == `I2C_ADDR_OFS)) begin
			model_addr = d[7:0];
		end
		if (in_window(a) && (a[4:0] == `I2C_DATA_OFS)) begin
			model_data = d[15:0];
		end
		check_value("gpio", {16'h0, gpio}, {16'h0, model_gpio});
	endtask

	// pairs of window and below-window addresses
	task automatic random_decode(input int count);
		addr_t a;
		word_t r;
		for (int n = 0; n < count; n++) begin
			r = $random(seed);
			a = {`PERIPH_WINDOW_TAG, r[4:0]};
			access_check(a, reg_model(a[4:0]));
			a = $random(seed);
			if (in_window(a)) begin
				a[5] = 1'b0;
			end
			access_check(a, 32'h0);
		end
	endtask

	// go and poll status until busy clears
	// then compare what the monitor saw
	task automatic run_frame(input addr_t sa, input word_t go_word, input word_t exp_frame,
			input logic second_go);
		word_t d;
		int    polls;
		logic  seen;
		int    start0;
		int    stop0;
		start0 = start_cnt;
		stop0  = stop_cnt;
		bus_write(sa, go_word);
		seen  = 1'b0;
		polls = 0;
		while (!seen && polls < 4) begin
			bus_read(sa, d);
			seen = d[`STAT_BUSY];
			polls++;
		end
		assert (seen) else begin
			errors++;
			$display("busy did not rise after go");
		end
		// go mid frame must be dropped
		if (second_go) begin
			repeat (3 * `I2C_DIV) @(negedge clk);
			bus_write(sa, go_word);
		end
		polls = 0;
		while (seen && polls < 100 * `I2C_DIV) begin
			bus_read(sa, d);
			seen = d[`STAT_BUSY];
			if (seen) begin
				check_value("status", d, BUSY_WORD);
			end
			polls++;
		end
		assert (!seen) else begin
			errors++;
			$display("busy did not fall at the end of the frame");
		end
		check_value("status", d, 32'h0);
		// stop and all frame bits come before busy drops
		check_value("stop conditions", stop_cnt - stop0, 1);
		check_value("frame bit count", mon_nbits, 24);
		check_value("frame bits", {8'h00, mon_bits}, exp_frame);
		// no late frame from a dropped go
		repeat (2 * `I2C_DIV) @(negedge clk);
		check_value("start conditions", start_cnt - start0, 1);
		// registers clear on done
		model_addr = 8'h0;
		model_data = 16'h0;
	endtask

	// pin monitor on stable values
	always @(negedge clk) begin
		if (!rst_n) begin
			prev_scl     = 1'b1;
			prev_sda     = 1'b1;
			in_frame     = 1'b0;
			scl_rises    = 0;
			start_cnt    = 0;
			stop_cnt     = 0;
			mon_nbits    = 0;
			mon_bits     = '0;
			proto_errors = 0;
		end else begin
			// start condition when sda falls with scl high
			if (scl && prev_scl && prev_sda && !sda_out && sda_oe) begin
				assert (!in_frame) else begin
					proto_errors++;
					$display("start condition inside a frame");
				end
				start_cnt++;
				in_frame  = 1'b1;
				scl_rises = 0;
				mon_nbits = 0;
				mon_bits  = '0;
			end
			// stop condition when sda rises with scl high
			if (scl && prev_scl && !prev_sda && sda_out && sda_oe) begin
				assert (in_frame && scl_rises == 28) else begin
					proto_errors++;
					$display("stop condition at the wrong point of a frame");
				end
				stop_cnt++;
				in_frame = 1'b0;
			end
			// 27 bit and ack pulses before the stop high phase on the 28th
			if (scl && !prev_scl && in_frame) begin
				scl_rises++;
				assert (scl_rises <= 28) else begin
					proto_errors++;
					$display("extra clock pulse before the stop condition");
				end
				if (scl_rises < 28 && scl_rises % 9 == 0) begin
					assert (!sda_oe) else begin
						proto_errors++;
						$display("line not released in an acknowledge slot");
					end
				end else if (scl_rises < 28) begin
					assert (sda_oe) else begin
						proto_errors++;
						$display("line released during a data bit");
					end
					mon_bits = {mon_bits[22:0], sda_out};
					mon_nbits++;
				end
			end
			prev_scl = scl;
			prev_sda = sda_out;
		end
	end

	// limit scales with the number of operations
	initial begin
		int limit;
		wait (stim_loaded);
		limit = num_ops * 30 * `I2C_DIV * 4 + 1000;
		repeat (limit) @(posedge clk);
		$display("timeout, stimulus did not finish within %0d clock cycles", limit);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] v;
		logic [31:0] e;
		adr         = '0;
		writedata   = '0;
		mmemdata    = '0;
		mmemdatah   = '0;
		memwrite    = 1'b0;
		rst_n       = 1'b0;
		seed        = 32'hcc60_e236;
		errors      = 0;
		model_addr  = 8'h0;
		model_data  = 16'h0;
		model_gpio  = '0;
		stim_loaded = 1'b0;
		$readmemh("dv/periph_stimulus.txt", stim);
		// opcode 0 ends the list
		num_ops = 0;
		while (num_ops < MAX_OPS && stim[num_ops*4] != 0) begin
			num_ops++;
		end
		stim_loaded = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// idle bus pins and outputs
		check_bit("scl", scl, 1'b1);
		check_bit("sda_out", sda_out, 1'b1);
		check_bit("sda_oe", sda_oe, 1'b1);
		check_value("gpio", {16'h0, gpio}, 32'h0);
		assert (num_ops > 0) else begin
			errors++;
			$display("stimulus file holds no operations");
		end
		for (int i = 0; i < num_ops; i++) begin
			op = stim[4*i];
			a  = stim[4*i+1];
			v  = stim[4*i+2];
			e  = stim[4*i+3];
			case (op)
				32'd1:   apply_write(a, v);
				32'd2:   access_check(a, e);
				32'd3:   run_frame(a, v, e, 1'b0);
				32'd4:   random_decode(v);
				32'd5:   run_frame(a, v, e, 1'b1);
				default: begin
					errors++;
					$display("unknown opcode %h in stimulus line %0d", op, i);
				end
			endcase
		end
		$display("errors: %0d value, %0d protocol", errors, proto_errors);
		if (errors == 0 && proto_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== periph_bus.f ====
+incdir+rtl
rtl/bus_pkg.sv
rtl/i2c_pkg.sv
rtl/addr_decode.sv
rtl/io_regs.sv
rtl/i2c_master.sv
rtl/periph_top.sv
dv/tb_periph.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the periph_bus testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_periph -f periph_bus.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_periph > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides the result
if grep -q "Testbench failed" "$log"; then
	echo "simulation reported failure, see $log"
	exit 1
fi
echo "simulation clean, see $log"
exit 0

// ==== dv/periph_stimulus.txt ====
// columns: opcode address value expected, all hex
// opcode 1 write, 2 read and compare, 3 frame, 4 random decode, 5 frame plus second go, 0 end
00000002 ffffffe7 00000000 00000000
00000001 ffffff00 abcd1234 00000000
00000001 ffffffe8 000000a5 00000000
00000001 ffffffe9 0000c33c 00000000
00000002 ffffffe8 00000000 000000a5
00000002 ffffffe9 00000000 0000c33c
00000004 00000000 00000010 00000000
00000003 ffffffe7 00000010 00a5c33c
00000002 ffffffe8 00000000 00000000
00000002 ffffffe9 00000000 00000000
00000002 ffffffe7 00000000 00000000
00000001 ffffff00 00005a5a 00000000
00000001 ffffffe8 ffffff3c 00000000
00000001 ffffffe9 12348001 00000000
00000002 ffffffe8 00000000 0000003c
00000002 ffffffe9 00000000 00008001
00000005 ffffffe7 00000010 003c8001
00000002 ffffffe8 00000000 00000000
00000004 00000000 00000008 00000000
00000000 00000000 00000000 00000000
